// File: udp_config.svh
// -----------------------------------------------
// Data path configuration
// Stream widths, port count, queue depth and the
// register map shared by all data path blocks
// -----------------------------------------------
`ifndef UDP_CONFIG_SVH
`define UDP_CONFIG_SVH

// Stream bus
`define UDP_DATA_WIDTH 64
`define UDP_CTRL_WIDTH 8

// Control value of the module header word
`define UDP_CTRL_HDR 8'hff

// Ports and queues
`define UDP_NUM_PORTS 4
`define UDP_OQ_DEPTH 16

// Register ring
`define UDP_REG_ADDR_WIDTH 8
`define UDP_REG_DATA_WIDTH 32

// Register map
`define UDP_REG_DEFAULT_PORT 8'h00
`define UDP_REG_NUM_PKTS 8'h01
`define UDP_REG_OQ_PKTS_BASE 8'h10

// Read data when no stage claims the address
`define UDP_REG_NO_REPLY 32'hdead_beef

`endif

// File: udp_pkt_pkg.sv
// -----------------------------------------------
// Packet stream types
// Module header layout, the two decodings of a
// header word, and the beat of every stream link
// -----------------------------------------------
`include "udp_config.svh"

package udp_pkt_pkg;

   // Module header, first word of every packet
   typedef struct packed {
      logic [7:0]  dst_ports;
      logic [7:0]  src_port;
      // Words in the packet, header word included
      logic [15:0] word_len;
      logic [31:0] reserved;
   } pkt_hdr_t;

   // Same 64 bits as raw payload or as a header
   typedef union packed {
      logic [`UDP_DATA_WIDTH-1:0] raw;
      pkt_hdr_t                   hdr;
   } pkt_word_u;

   // One word on a stream link
   typedef struct packed {
      pkt_word_u                  data;
      logic [`UDP_CTRL_WIDTH-1:0] ctrl;
   } pkt_beat_t;

   // -----------------------------------------------
   // Control byte decode
   // -----------------------------------------------
   function automatic logic is_hdr(input logic [`UDP_CTRL_WIDTH-1:0] ctrl);
      return ctrl == `UDP_CTRL_HDR;
   endfunction

   // Last word has any nonzero control except the header mark
   function automatic logic is_eop(input logic [`UDP_CTRL_WIDTH-1:0] ctrl);
      return (ctrl != '0) && (ctrl != `UDP_CTRL_HDR);
   endfunction

endpackage

// File: udp_reg_pkg.sv
// -----------------------------------------------
// Register ring types
// Request word passed from stage to stage and the
// request held by the host
// -----------------------------------------------
`include "udp_config.svh"

package udp_reg_pkg;

   // One hop of the ring
   typedef struct packed {
      logic                           valid;
      // 1 means read
      logic                           rd_wr_n;
      logic [`UDP_REG_ADDR_WIDTH-1:0] addr;
      logic [`UDP_REG_DATA_WIDTH-1:0] data;
      // Set by the stage that owns addr
      logic                           ack;
   } reg_req_t;

   // Host side request
   typedef struct packed {
      logic [`UDP_REG_ADDR_WIDTH-1:0] addr;
      logic                           rd_wr_n;
      logic [`UDP_REG_DATA_WIDTH-1:0] wr_data;
   } reg_host_req_t;

endpackage

// File: input_arbiter.sv
// -----------------------------------------------
// Input arbiter
// Round-robin merge of the input ports onto one
// stream bus, a whole packet per grant; stamps
// the source port into each header
// -----------------------------------------------
`include "udp_config.svh"

module input_arbiter
   import udp_pkt_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  pkt_beat_t                 in_beat [`UDP_NUM_PORTS],
   input  logic [`UDP_NUM_PORTS-1:0] in_valid,
   output logic [`UDP_NUM_PORTS-1:0] in_ready,
   output pkt_beat_t                 arb_beat,
   output logic                      arb_valid,
   input  logic                      arb_ready
);

   // Port count is a power of two, so the index wraps by itself
   localparam int PW = $clog2(`UDP_NUM_PORTS);

   logic [PW-1:0] cur_port;
   logic          locked;
   logic [PW-1:0] sel;
   logic [PW-1:0] idx;
   logic          found;
   logic          out_free;
   logic          xfer;
   pkt_word_u     word;

   // Next requester after the last grant, unless mid packet
   always_comb
   begin
      sel   = cur_port;
      found = 1'b0;
      idx   = cur_port;
      for (int k = 1; k <= `UDP_NUM_PORTS; k++)
      begin
         idx = cur_port + PW'(k);
         if (!found && in_valid[idx])
         begin
            sel   = idx;
            found = 1'b1;
         end
      end
      if (locked)
         sel = cur_port;
   end

   assign out_free = !arb_valid || arb_ready;

   always_comb
   begin
      in_ready      = '0;
      in_ready[sel] = out_free && in_valid[sel];
   end

   assign xfer = |(in_valid & in_ready);

   // Source port goes into the header word only
   always_comb
   begin
      word = in_beat[sel].data;
      if (is_hdr(in_beat[sel].ctrl))
         word.hdr.src_port = 8'(sel);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cur_port  <= '0;
         locked    <= 1'b0;
         arb_valid <= 1'b0;
      end
      else if (xfer)
      begin
         cur_port  <= sel;
         locked    <= !is_eop(in_beat[sel].ctrl);
         arb_valid <= 1'b1;
      end
      else if (arb_ready)
         arb_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         arb_beat.data <= word;
         arb_beat.ctrl <= in_beat[sel].ctrl;
      end
   end

   // A granted packet starts with its header and carries no other
   a_pkt_framing: assert property (@(posedge clk) disable iff (reset)
      xfer |-> (is_hdr(in_beat[sel].ctrl) == !locked));

endmodule

// File: output_port_lookup.sv
// -----------------------------------------------
// Output port lookup
// One-beat pipeline stage that fills an empty
// destination with the default port, counts
// packets, and serves its registers on the ring
// -----------------------------------------------
`include "udp_config.svh"

module output_port_lookup
   import udp_pkt_pkg::*, udp_reg_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  pkt_beat_t arb_beat,
   input  logic      arb_valid,
   output logic      arb_ready,
   output pkt_beat_t lut_beat,
   output logic      lut_valid,
   input  logic      lut_ready,
   input  reg_req_t  ring_in,
   output reg_req_t  ring_out
);

   logic [7:0]                     default_port;
   logic [`UDP_REG_DATA_WIDTH-1:0] num_pkts;
   pkt_word_u                      word;
   logic                           hdr_in;
   logic                           xfer;

   assign arb_ready = arb_valid && (!lut_valid || lut_ready);
   assign xfer      = arb_valid && arb_ready;
   assign hdr_in    = is_hdr(arb_beat.ctrl);

   always_comb
   begin
      word = arb_beat.data;
      if (hdr_in && word.hdr.dst_ports == '0)
         word.hdr.dst_ports = default_port;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         lut_valid <= 1'b0;
      else if (xfer)
         lut_valid <= 1'b1;
      else if (lut_ready)
         lut_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
      begin
         lut_beat.data <= word;
         lut_beat.ctrl <= arb_beat.ctrl;
      end
   end

   // -----------------------------------------------
   // Registers and ring stage
   // -----------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         default_port <= 8'h01;
         num_pkts     <= '0;
         ring_out     <= '0;
      end
      else
      begin
         if (xfer && hdr_in)
            num_pkts <= num_pkts + 1'b1;
         ring_out <= ring_in;
         if (ring_in.valid)
         begin
            case (ring_in.addr)
               `UDP_REG_DEFAULT_PORT:
               begin
                  ring_out.ack <= 1'b1;
                  if (ring_in.rd_wr_n)
                     ring_out.data <= 32'(default_port);
                  else
                     default_port <= ring_in.data[7:0];
               end
               `UDP_REG_NUM_PKTS:
               begin
                  ring_out.ack <= 1'b1;
                  if (ring_in.rd_wr_n)
                     ring_out.data <= num_pkts;
               end
            endcase
         end
      end
   end

endmodule

// File: output_queues.sv
// -----------------------------------------------
// Output queues
// Per-port FIFOs fed from one stream; a packet is
// copied to every port in its one-hot destination
// once all of them have room for it. Counts sent
// packets per port for the register ring
// -----------------------------------------------
`include "udp_config.svh"

module output_queues
   import udp_pkt_pkg::*, udp_reg_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  pkt_beat_t                 lut_beat,
   input  logic                      lut_valid,
   output logic                      lut_ready,
   output pkt_beat_t                 out_beat [`UDP_NUM_PORTS],
   output logic [`UDP_NUM_PORTS-1:0] out_valid,
   input  logic [`UDP_NUM_PORTS-1:0] out_ready,
   input  reg_req_t                  ring_in,
   output reg_req_t                  ring_out
);

   localparam int AW = $clog2(`UDP_OQ_DEPTH);
   localparam int PW = $clog2(`UDP_NUM_PORTS);

   logic [`UDP_NUM_PORTS-1:0]      room;
   logic [`UDP_NUM_PORTS-1:0]      hdr_dst;
   logic [`UDP_NUM_PORTS-1:0]      pkt_mask;
   logic [`UDP_NUM_PORTS-1:0]      wr_en;
   logic                           in_pkt;
   logic                           hdr_beat;
   logic                           start;
   logic                           xfer;
   logic [`UDP_REG_DATA_WIDTH-1:0] oq_pkts [`UDP_NUM_PORTS];
   logic                           reg_hit;
   logic [PW-1:0]                  reg_sel;

   assign hdr_dst  = lut_beat.data.hdr.dst_ports[`UDP_NUM_PORTS-1:0];
   assign hdr_beat = is_hdr(lut_beat.ctrl);
   assign start    = !in_pkt && lut_valid && hdr_beat;

   // Header waits until every destination can take the whole packet
   assign lut_ready = in_pkt || (lut_valid && (!hdr_beat || &(room | ~hdr_dst)));
   assign xfer      = lut_valid && lut_ready;

   always_comb
   begin
      wr_en = '0;
      if (xfer && in_pkt)
         wr_en = pkt_mask;
      else if (xfer && start)
         wr_en = hdr_dst;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         in_pkt   <= 1'b0;
         pkt_mask <= '0;
      end
      else if (xfer && start)
      begin
         in_pkt   <= 1'b1;
         pkt_mask <= hdr_dst;
      end
      else if (xfer && is_eop(lut_beat.ctrl))
         in_pkt <= 1'b0;
   end

   // -----------------------------------------------
   // Per-port FIFO with registered output
   // -----------------------------------------------
   for (genvar i = 0; i < `UDP_NUM_PORTS; i++)
   begin : g_fifo
      pkt_beat_t                      mem [`UDP_OQ_DEPTH];
      logic [AW:0]                    wr_ptr;
      logic [AW:0]                    rd_ptr;
      logic [AW:0]                    count;
      logic [15:0]                    free_words;
      logic                           pop;
      logic                           valid_q;
      pkt_beat_t                      beat_q;
      logic [`UDP_REG_DATA_WIDTH-1:0] pkt_cnt;

      assign count      = wr_ptr - rd_ptr;
      assign free_words = 16'(`UDP_OQ_DEPTH) - 16'(count);
      assign room[i]    = free_words >= lut_beat.data.hdr.word_len;
      assign pop        = (count != '0) && (!valid_q || out_ready[i]);

      always_ff @(posedge clk)
      begin
         if (wr_en[i])
            mem[wr_ptr[AW-1:0]] <= lut_beat;
         if (pop)
            beat_q <= mem[rd_ptr[AW-1:0]];
      end

      always_ff @(posedge clk)
      begin
         if (reset)
         begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            valid_q <= 1'b0;
            pkt_cnt <= '0;
         end
         else
         begin
            if (wr_en[i])
               wr_ptr <= wr_ptr + 1'b1;
            if (pop)
            begin
               rd_ptr  <= rd_ptr + 1'b1;
               valid_q <= 1'b1;
            end
            else if (out_ready[i])
               valid_q <= 1'b0;
            if (valid_q && out_ready[i] && is_eop(beat_q.ctrl))
               pkt_cnt <= pkt_cnt + 1'b1;
         end
      end

      assign out_valid[i] = valid_q;
      assign out_beat[i]  = beat_q;
      assign oq_pkts[i]   = pkt_cnt;

      a_no_overflow: assert property (@(posedge clk) disable iff (reset)
         wr_en[i] |-> (count < `UDP_OQ_DEPTH));
   end

   // Sent-packet counters on the ring
   assign reg_hit = (ring_in.addr >= `UDP_REG_OQ_PKTS_BASE) &&
                    (ring_in.addr < `UDP_REG_OQ_PKTS_BASE + `UDP_NUM_PORTS);
   assign reg_sel = PW'(ring_in.addr - `UDP_REG_OQ_PKTS_BASE);

   always_ff @(posedge clk)
   begin
      if (reset)
         ring_out <= '0;
      else
      begin
         ring_out <= ring_in;
         if (ring_in.valid && reg_hit)
         begin
            ring_out.ack <= 1'b1;
            if (ring_in.rd_wr_n)
               ring_out.data <= oq_pkts[reg_sel];
         end
      end
   end

endmodule

// File: udp_reg_master.sv
// -----------------------------------------------
// Register ring master
// Launches one host request onto the ring, waits
// for it to come back, and returns the reply
// -----------------------------------------------
`include "udp_config.svh"

module udp_reg_master
   import udp_reg_pkg::*;
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           host_req,
   input  reg_host_req_t                  host_req_data,
   output logic                           host_ack,
   output logic [`UDP_REG_DATA_WIDTH-1:0] host_rd_data,
   output reg_req_t                       ring_out,
   input  reg_req_t                       ring_in
);

   logic     busy;
   // Return stage of the ring
   reg_req_t ring_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy         <= 1'b0;
         host_ack     <= 1'b0;
         host_rd_data <= '0;
         ring_out     <= '0;
         ring_q       <= '0;
      end
      else
      begin
         host_ack       <= 1'b0;
         ring_out.valid <= 1'b0;
         ring_q         <= ring_in;
         // host_ack high means the host has not yet dropped the old request
         if (host_req && !busy && !host_ack)
         begin
            busy             <= 1'b1;
            ring_out.valid   <= 1'b1;
            ring_out.rd_wr_n <= host_req_data.rd_wr_n;
            ring_out.addr    <= host_req_data.addr;
            ring_out.data    <= host_req_data.wr_data;
            ring_out.ack     <= 1'b0;
         end
         if (ring_q.valid)
         begin
            busy     <= 1'b0;
            host_ack <= 1'b1;
            if (ring_q.rd_wr_n && !ring_q.ack)
               host_rd_data <= `UDP_REG_NO_REPLY;
            else
               host_rd_data <= ring_q.data;
         end
      end
   end

   a_ring_owned: assert property (@(posedge clk) disable iff (reset)
      ring_in.valid |-> busy);

endmodule

// File: user_data_path.sv
// -----------------------------------------------
// User data path top level
// Input arbiter, output port lookup and output
// queues on the stream path, with the register
// ring closed through the ring master
// -----------------------------------------------
`include "udp_config.svh"

module user_data_path
   import udp_pkt_pkg::*, udp_reg_pkg::*;
(
   input  logic                           clk,
   input  logic                           reset,
   input  pkt_beat_t                      in_beat [`UDP_NUM_PORTS],
   input  logic [`UDP_NUM_PORTS-1:0]      in_valid,
   output logic [`UDP_NUM_PORTS-1:0]      in_ready,
   output pkt_beat_t                      out_beat [`UDP_NUM_PORTS],
   output logic [`UDP_NUM_PORTS-1:0]      out_valid,
   input  logic [`UDP_NUM_PORTS-1:0]      out_ready,
   input  logic                           host_req,
   input  reg_host_req_t                  host_req_data,
   output logic                           host_ack,
   output logic [`UDP_REG_DATA_WIDTH-1:0] host_rd_data
);

   // Stream links
   pkt_beat_t arb_beat;
   logic      arb_valid;
   logic      arb_ready;
   pkt_beat_t lut_beat;
   logic      lut_valid;
   logic      lut_ready;

   // Ring hops
   reg_req_t  ring_mst_lut;
   reg_req_t  ring_lut_oq;
   reg_req_t  ring_oq_mst;

   input_arbiter u_input_arbiter (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .arb_beat  (arb_beat),
      .arb_valid (arb_valid),
      .arb_ready (arb_ready)
   );

   output_port_lookup u_output_port_lookup (
      .clk       (clk),
      .reset     (reset),
      .arb_beat  (arb_beat),
      .arb_valid (arb_valid),
      .arb_ready (arb_ready),
      .lut_beat  (lut_beat),
      .lut_valid (lut_valid),
      .lut_ready (lut_ready),
      .ring_in   (ring_mst_lut),
      .ring_out  (ring_lut_oq)
   );

   output_queues u_output_queues (
      .clk       (clk),
      .reset     (reset),
      .lut_beat  (lut_beat),
      .lut_valid (lut_valid),
      .lut_ready (lut_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .ring_in   (ring_lut_oq),
      .ring_out  (ring_oq_mst)
   );

   udp_reg_master u_udp_reg_master (
      .clk           (clk),
      .reset         (reset),
      .host_req      (host_req),
      .host_req_data (host_req_data),
      .host_ack      (host_ack),
      .host_rd_data  (host_rd_data),
      .ring_out      (ring_mst_lut),
      .ring_in       (ring_oq_mst)
   );

endmodule

// File: tb_user_data_path.sv
// -----------------------------------------------
// Data path testbench
// Directed tests for routing, arbitration,
// multicast, default port, back-pressure and the
// register counters of the user data path
// -----------------------------------------------
`include "udp_config.svh"

module tb_user_data_path
   import udp_pkt_pkg::*, udp_reg_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NP = `UDP_NUM_PORTS;
   // Tests need a few hundred cycles, this leaves a wide margin
   localparam int TIMEOUT_CYCLES = 4000;

   logic                           clk;
   logic                           reset;
   pkt_beat_t                      in_beat [NP];
   logic [NP-1:0]                  in_valid;
   logic [NP-1:0]                  in_ready;
   pkt_beat_t                      out_beat [NP];
   logic [NP-1:0]                  out_valid;
   logic [NP-1:0]                  out_ready;
   logic                           host_req;
   reg_host_req_t                  host_req_data;
   logic                           host_ack;
   logic [`UDP_REG_DATA_WIDTH-1:0] host_rd_data;

   // Expected beats, one queue per output and source port
   pkt_beat_t   exp_q [NP*NP][$];
   int          rem [NP];
   int          cur_src [NP];
   int          port_pkts [NP];
   int          pkts_sent;
   logic [7:0]  default_dst;
   logic [31:0] rng_state;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_cnt;

   user_data_path u_dut (
      .clk           (clk),
      .reset         (reset),
      .in_beat       (in_beat),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .out_beat      (out_beat),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .host_req      (host_req),
      .host_req_data (host_req_data),
      .host_ack      (host_ack),
      .host_rd_data  (host_rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         $display("TB FAILED");
         $finish;
      end
   end

   // -----------------------------------------------
   // Random payload and checks
   // -----------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   task automatic compare_beat(input string name, input pkt_beat_t exp, input pkt_beat_t got);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic compare_reg(input string name, input logic [`UDP_REG_DATA_WIDTH-1:0] exp,
                              input logic [`UDP_REG_DATA_WIDTH-1:0] got);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // Output sinks, checked at the falling edge where all signals are settled
   task automatic check_outputs();
      pkt_beat_t got;
      pkt_beat_t exp;
      int        s;
      for (int o = 0; o < NP; o++)
      begin
         if (out_valid[o] && out_ready[o])
         begin
            got = out_beat[o];
            if (rem[o] == 0)
            begin
               s = int'(got.data.hdr.src_port);
               if (s < NP && exp_q[o*NP+s].size() != 0)
               begin
                  cur_src[o] = s;
                  exp        = exp_q[o*NP+s][0];
                  rem[o]     = int'(exp.data.hdr.word_len);
               end
            end
            if (rem[o] == 0)
            begin
               $display("Unexpected beat on output port %0d at %0t ns", o, $time);
               errors++;
            end
            else
            begin
               exp = exp_q[o*NP+cur_src[o]].pop_front();
               compare_beat($sformatf("out_beat[%0d]", o), exp, got);
               rem[o]--;
            end
         end
      end
   endtask

   always @(negedge clk)
   begin
      if (!reset)
         check_outputs();
   end

   // -----------------------------------------------
   // Stimulus tasks
   // -----------------------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Builds one packet, queues the expected copies and drives it on a port
   task automatic send_packet(input int port, input logic [3:0] dst, input int len);
      pkt_beat_t  beats [16];
      pkt_beat_t  exp_hdr;
      logic [3:0] out_dst;
      logic       taken;
      beats[0].ctrl               = `UDP_CTRL_HDR;
      beats[0].data.hdr.dst_ports = {4'h0, dst};
      beats[0].data.hdr.src_port  = 8'(next_rand());
      beats[0].data.hdr.word_len  = 16'(len);
      beats[0].data.hdr.reserved  = next_rand();
      for (int i = 1; i < len; i++)
      begin
         beats[i].data.raw = {next_rand(), next_rand()};
         beats[i].ctrl     = (i == len - 1) ? 8'(1 << (len % 8)) : 8'h00;
      end
      // Lookup fills an empty destination, arbiter stamps the source
      out_dst                    = (dst == 4'h0) ? default_dst[3:0] : dst;
      exp_hdr                    = beats[0];
      exp_hdr.data.hdr.src_port  = 8'(port);
      exp_hdr.data.hdr.dst_ports = {4'h0, out_dst};
      pkts_sent++;
      for (int o = 0; o < NP; o++)
      begin
         if (out_dst[o])
         begin
            exp_q[o*NP+port].push_back(exp_hdr);
            for (int i = 1; i < len; i++)
               exp_q[o*NP+port].push_back(beats[i]);
            port_pkts[o]++;
         end
      end
      for (int i = 0; i < len; i++)
      begin
         in_beat[port]  = beats[i];
         in_valid[port] = 1'b1;
         do
         begin
            @(negedge clk);
            taken = in_ready[port];
            next_cycle();
         end
         while (!taken);
      end
      in_valid[port] = 1'b0;
   endtask

   task automatic wait_drain();
      int left;
      do
      begin
         next_cycle();
         left = 0;
         for (int q = 0; q < NP * NP; q++)
            left += exp_q[q].size();
      end
      while (left != 0);
   endtask

   task automatic reg_access(input logic [7:0] addr, input logic rd,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      logic ack;
      int   n;
      host_req_data.addr    = addr;
      host_req_data.rd_wr_n = rd;
      host_req_data.wr_data = wdata;
      host_req              = 1'b1;
      n                     = 0;
      ack                   = 1'b0;
      while (!ack)
      begin
         @(negedge clk);
         ack   = host_ack;
         rdata = host_rd_data;
         n++;
         next_cycle();
      end
      host_req = 1'b0;
      // Launch happens one edge after the request is raised
      if (n - 2 != 4)
      begin
         $display("Register round trip took %0d cycles instead of 4", n - 2);
         errors++;
      end
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      reg_access(addr, 1'b0, data, unused);
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      reg_access(addr, 1'b1, 32'h0, data);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("%s: ok", name);
      else
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   // -----------------------------------------------
   // Directed tests
   // -----------------------------------------------
   task automatic test_single_route();
      int e0;
      e0 = errors;
      send_packet(1, 4'b0100, 5);
      wait_drain();
      report_test("single_route", e0);
   endtask

   task automatic port_burst(input int port);
      send_packet(port, 4'b1000, 3 + port);
      send_packet(port, 4'b0001 << port, 4 + port);
   endtask

   task automatic test_arbitration();
      int e0;
      e0 = errors;
      fork
         port_burst(0);
         port_burst(1);
         port_burst(2);
         port_burst(3);
      join
      wait_drain();
      report_test("arbitration", e0);
   endtask

   task automatic test_multicast();
      int e0;
      e0 = errors;
      send_packet(2, 4'b1011, 6);
      wait_drain();
      report_test("multicast", e0);
   endtask

   task automatic test_default_port();
      int          e0;
      logic [31:0] rd;
      e0 = errors;
      reg_write(`UDP_REG_DEFAULT_PORT, 32'h0000_0008);
      default_dst = 8'h08;
      send_packet(0, 4'b0000, 4);
      wait_drain();
      reg_read(`UDP_REG_DEFAULT_PORT, rd);
      compare_reg("default_port", 32'h0000_0008, rd);
      report_test("default_port", e0);
   endtask

   task automatic test_back_pressure();
      int   e0;
      logic done;
      e0           = errors;
      done         = 1'b0;
      out_ready[0] = 1'b0;
      fork
         begin
            for (int k = 0; k < 3; k++)
               send_packet(3, 4'b0001, 8);
            done = 1'b1;
         end
         begin
            // Three 8-word packets overflow one queue plus its output stage
            repeat (60)
               next_cycle();
            if (done)
            begin
               $display("Input port 3 was not stalled while output 0 was blocked");
               errors++;
            end
            out_ready[0] = 1'b1;
         end
      join
      wait_drain();
      report_test("back_pressure", e0);
   endtask

   task automatic test_counters();
      int          e0;
      logic [31:0] rd;
      e0 = errors;
      reg_read(`UDP_REG_NUM_PKTS, rd);
      compare_reg("num_pkts", 32'(pkts_sent), rd);
      for (int i = 0; i < NP; i++)
      begin
         reg_read(8'(`UDP_REG_OQ_PKTS_BASE + i), rd);
         compare_reg($sformatf("oq_pkts[%0d]", i), 32'(port_pkts[i]), rd);
      end
      reg_read(8'h40, rd);
      compare_reg("unused_reg", `UDP_REG_NO_REPLY, rd);
      report_test("counters", e0);
   endtask

   initial
   begin
      reset         = 1'b1;
      in_valid      = '0;
      out_ready     = '1;
      host_req      = 1'b0;
      host_req_data = '0;
      for (int p = 0; p < NP; p++)
      begin
         in_beat[p]   = '0;
         rem[p]       = 0;
         cur_src[p]   = 0;
         port_pkts[p] = 0;
      end
      pkts_sent    = 0;
      default_dst  = 8'h01;
      rng_state    = 32'h8962_afd1;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      repeat (10)
         @(posedge clk);
      #1;
      reset = 1'b0;
      next_cycle();

      test_single_route();
      test_arbitration();
      test_multicast();
      test_default_port();
      test_back_pressure();
      test_counters();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: udp_datapath.f
+incdir+.
udp_pkt_pkg.sv
udp_reg_pkg.sv
input_arbiter.sv
output_port_lookup.sv
output_queues.sv
udp_reg_master.sv
user_data_path.sv
tb_user_data_path.sv

// File: Bender.yml
package:
  name: udp_datapath

export_include_dirs:
  - .

sources:
  # Packages first, then the blocks, then the top level
  - udp_pkt_pkg.sv
  - udp_reg_pkg.sv
  - input_arbiter.sv
  - output_port_lookup.sv
  - output_queues.sv
  - udp_reg_master.sv
  - user_data_path.sv

  - target: test
    files:
      - tb_user_data_path.sv
